// File: project.f
src/datapathPkg.sv
src/registerFile.sv
src/busMux.sv
src/alu.sv
src/specialRegisters.sv
src/datapath.sv
tb/datapath_asserts.sv
tb/datapathTb.sv

// File: src/alu.sv
module alu import datapathPkg::*; (
	input aluOpcode opcode,
	input logic incPc,
	input logic [wordWidth-1:0] y,
	input logic [wordWidth-1:0] bus,
	output logic [2*wordWidth-1:0] result
);

	logic [4:0] amount;
	logic [2*wordWidth-1:0] doubled;
	logic [2*wordWidth-1:0] rotateRight;
	logic [2*wordWidth-1:0] rotateLeft;
	logic signed [2*wordWidth-1:0] product;
	logic signed [wordWidth-1:0] quotient;
	logic signed [wordWidth-1:0] remainder;
	logic [wordWidth-1:0] word;

	// Shift distance comes from the low five bits of the second operand.
	assign amount = bus[4:0];

	// Rotates fall out of shifting two copies of y side by side.
	assign doubled = {y, y};
	assign rotateRight = doubled >> amount;
	assign rotateLeft = doubled << amount;

	assign product = $signed(y) * $signed(bus); // Both operands sign-extend to 64 bits.

	always_comb begin
		if (bus == '0) begin
			quotient = '1;
			remainder = y;
		end else begin
			quotient = $signed(y) / $signed(bus);
			remainder = $signed(y) % $signed(bus);
		end
	end

	// Single-word results, placed in the low half.
	always_comb begin
		case (opcode)
			opAdd:   word = y + bus;
			opSub:   word = y - bus;
			opAnd:   word = y & bus;
			opOr:    word = y | bus;
			opShra:  word = $signed(y) >>> amount;
			opShr:   word = y >> amount;
			opShl:   word = y << amount;
			opRor:   word = rotateRight[wordWidth-1:0];
			opRol:   word = rotateLeft[2*wordWidth-1:wordWidth];
			opNeg:   word = '0 - bus;
			opNot:   word = ~bus;
			default: word = '0;
		endcase
	end

	always_comb begin
		if (incPc) begin
			// The PC increment wins over whatever opcode is present.
			result = {{wordWidth{1'b0}}, bus + 32'd1};
		end else begin
			case (opcode)
				opMul:   result = product;
				opDiv:   result = {remainder, quotient}; // Remainder high, quotient low.
				default: result = {{wordWidth{1'b0}}, word};
			endcase
		end
	end

endmodule

// File: src/busMux.sv
module busMux import datapathPkg::*; (
	input busStrobes drive,
	input logic [wordWidth-1:0] general,
	input logic [wordWidth-1:0] hi,
	input logic [wordWidth-1:0] lo,
	input logic [wordWidth-1:0] zHigh,
	input logic [wordWidth-1:0] zLow,
	input logic [wordWidth-1:0] pc,
	input logic [wordWidth-1:0] mdr,
	input logic [wordWidth-1:0] inport,
	input logic [wordWidth-1:0] constant,
	output logic [wordWidth-1:0] bus
);

	busSource source;

	// Priority order only matters if the one-hot rule is broken.
	always_comb begin
		if (|drive.regOut) begin
			source = sourceGeneral;
		end else if (drive.hiOut) begin
			source = sourceHi;
		end else if (drive.loOut) begin
			source = sourceLo;
		end else if (drive.zHighOut) begin
			source = sourceZHigh;
		end else if (drive.zLowOut) begin
			source = sourceZLow;
		end else if (drive.pcOut) begin
			source = sourcePc;
		end else if (drive.mdrOut) begin
			source = sourceMdr;
		end else if (drive.inportOut) begin
			source = sourceInport;
		end else if (drive.cOut) begin
			source = sourceConstant;
		end else begin
			source = sourceNone;
		end
	end

	always_comb begin
		case (source)
			sourceGeneral:  bus = general;
			sourceHi:       bus = hi;
			sourceLo:       bus = lo;
			sourceZHigh:    bus = zHigh;
			sourceZLow:     bus = zLow;
			sourcePc:       bus = pc;
			sourceMdr:      bus = mdr;
			sourceInport:   bus = inport;
			sourceConstant: bus = constant;
			default:        bus = '0; // Idle bus reads zero.
		endcase
	end

endmodule

// File: src/datapath.sv
module datapath import datapathPkg::*; (
	input logic Clock,
	input logic reset,
	input loadStrobes load,
	input busStrobes drive,
	input logic read,
	input logic incPc,
	input aluOpcode opcode,
	input logic [wordWidth-1:0] memoryData,
	input logic [wordWidth-1:0] inportData,
	output logic [wordWidth-1:0] bus,
	output logic [wordWidth-1:0] memoryAddress
);

	logic [wordWidth-1:0] general;
	logic [wordWidth-1:0] pc;
	logic [wordWidth-1:0] mdr;
	logic [wordWidth-1:0] hi;
	logic [wordWidth-1:0] lo;
	logic [wordWidth-1:0] y;
	logic [wordWidth-1:0] inport;
	logic [wordWidth-1:0] zHigh;
	logic [wordWidth-1:0] zLow;
	logic [wordWidth-1:0] constant;
	logic [2*wordWidth-1:0] aluResult;

	registerFile generalRegisters (
		.Clock(Clock),
		.reset(reset),
		.regIn(load.regIn),
		.regOut(drive.regOut),
		.bus(bus),
		.selected(general)
	);

	specialRegisters special (
		.Clock(Clock),
		.reset(reset),
		.load(load),
		.read(read),
		.bus(bus),
		.aluResult(aluResult),
		.memoryData(memoryData),
		.inportData(inportData),
		.pc(pc),
		.mdr(mdr),
		.hi(hi),
		.lo(lo),
		.y(y),
		.inport(inport),
		.zHigh(zHigh),
		.zLow(zLow),
		.memoryAddress(memoryAddress),
		.constant(constant)
	);

	// Second operand always comes straight off the bus.
	alu arithmetic (
		.opcode(opcode),
		.incPc(incPc),
		.y(y),
		.bus(bus),
		.result(aluResult)
	);

	busMux sharedBus (
		.drive(drive),
		.general(general),
		.hi(hi),
		.lo(lo),
		.zHigh(zHigh),
		.zLow(zLow),
		.pc(pc),
		.mdr(mdr),
		.inport(inport),
		.constant(constant),
		.bus(bus)
	);

endmodule

// File: src/datapathPkg.sv
package datapathPkg;

	localparam int wordWidth = 32;
	localparam int registerCount = 16;

	// Codes for add and shra match the existing instruction encoding.
	typedef enum logic [4:0] {
		opAdd  = 5'b00011,
		opSub  = 5'b00100,
		opShra = 5'b00101,
		opShr  = 5'b00110,
		opShl  = 5'b00111,
		opRor  = 5'b01000,
		opRol  = 5'b01001,
		opAnd  = 5'b01010,
		opOr   = 5'b01011,
		opMul  = 5'b01110,
		opDiv  = 5'b01111,
		opNeg  = 5'b10000,
		opNot  = 5'b10001
	} aluOpcode;

	// Register load strobes, one per destination.
	typedef struct packed {
		logic [registerCount-1:0] regIn; // One-hot general register select.
		logic hiIn;
		logic loIn;
		logic yIn;
		logic zIn;
		logic pcIn;
		logic irIn;
		logic marIn;
		logic mdrIn;
		logic inportIn;
	} loadStrobes;

	// Bus-out strobes. Only one of these may be high in a given cycle.
	typedef struct packed {
		logic [registerCount-1:0] regOut;
		logic hiOut;
		logic loOut;
		logic zHighOut;
		logic zLowOut;
		logic pcOut;
		logic mdrOut;
		logic inportOut;
		logic cOut;
	} busStrobes;

	typedef enum logic [3:0] {
		sourceNone,
		sourceGeneral,
		sourceHi,
		sourceLo,
		sourceZHigh,
		sourceZLow,
		sourcePc,
		sourceMdr,
		sourceInport,
		sourceConstant
	} busSource;

	typedef struct packed {
		logic [4:0] opcode;
		logic [3:0] ra;
		logic [3:0] rb;
		logic [3:0] rc;
		logic [14:0] unused;
	} registerFormat;

	typedef struct packed {
		logic [4:0] opcode;
		logic [3:0] ra;
		logic [3:0] rb;
		logic [18:0] constant; // Signed immediate.
	} immediateFormat;

	// The same IR word seen as either instruction format.
	typedef union packed {
		registerFormat registerForm;
		immediateFormat immediateForm;
	} instructionWord;

endpackage

// File: src/registerFile.sv
module registerFile import datapathPkg::*; (
	input logic Clock,
	input logic reset,
	input logic [registerCount-1:0] regIn,
	input logic [registerCount-1:0] regOut,
	input logic [wordWidth-1:0] bus,
	output logic [wordWidth-1:0] selected
);

	logic [wordWidth-1:0] registers [registerCount];

	// Every register whose load bit is high takes the bus value.
	always_ff @(posedge Clock) begin
		for (int i = 0; i < registerCount; i++) begin
			if (reset) begin
				registers[i] <= '0;
			end else if (regIn[i]) begin
				registers[i] <= bus;
			end
		end
	end

	// The strobe is one-hot, so the lowest set bit names the register.
	always_comb begin
		selected = '0;
		for (int i = registerCount - 1; i >= 0; i--) begin
			if (regOut[i]) begin
				selected = registers[i];
			end
		end
	end

endmodule

// File: src/specialRegisters.sv
module specialRegisters import datapathPkg::*; (
	input logic Clock,
	input logic reset,
	input loadStrobes load,
	input logic read,
	input logic [wordWidth-1:0] bus,
	input logic [2*wordWidth-1:0] aluResult,
	input logic [wordWidth-1:0] memoryData,
	input logic [wordWidth-1:0] inportData,
	output logic [wordWidth-1:0] pc,
	output logic [wordWidth-1:0] mdr,
	output logic [wordWidth-1:0] hi,
	output logic [wordWidth-1:0] lo,
	output logic [wordWidth-1:0] y,
	output logic [wordWidth-1:0] inport,
	output logic [wordWidth-1:0] zHigh,
	output logic [wordWidth-1:0] zLow,
	output logic [wordWidth-1:0] memoryAddress,
	output logic [wordWidth-1:0] constant
);

	instructionWord instruction;
	logic [2*wordWidth-1:0] z;
	logic [wordWidth-1:0] mdrNext;

	// A memory read takes priority over the bus as MDR source.
	assign mdrNext = read ? memoryData : bus;

	always_ff @(posedge Clock) begin
		if (reset) begin
			pc <= '0;
			instruction <= '0;
			memoryAddress <= '0;
			mdr <= '0;
			y <= '0;
			z <= '0;
			hi <= '0;
			lo <= '0;
			inport <= '0;
		end else begin
			if (load.pcIn) begin
				pc <= bus;
			end
			if (load.irIn) begin
				instruction <= bus;
			end
			if (load.marIn) begin
				memoryAddress <= bus;
			end
			if (load.mdrIn) begin
				mdr <= mdrNext;
			end
			if (load.yIn) begin
				y <= bus;
			end
			if (load.zIn) begin
				z <= aluResult; // Full 64-bit result, needed by mul and div.
			end
			if (load.hiIn) begin
				hi <= bus;
			end
			if (load.loIn) begin
				lo <= bus;
			end
			if (load.inportIn) begin
				inport <= inportData;
			end
		end
	end

	assign zHigh = z[2*wordWidth-1:wordWidth];
	assign zLow = z[wordWidth-1:0];

	// Sign-extend the 19-bit immediate field.
	assign constant = {{(wordWidth-19){instruction.immediateForm.constant[18]}},
		instruction.immediateForm.constant};

endmodule

// File: tb/datapathTb.sv
module datapathTb import datapathPkg::*; ();

	typedef struct packed {
		aluOpcode op;
		logic [wordWidth-1:0] a;
		logic [wordWidth-1:0] b;
		logic [18:0] imm;
	} testRow;

	logic Clock;
	logic reset;
	loadStrobes load;
	busStrobes drive;
	logic read;
	logic incPc;
	aluOpcode opcode;
	logic [wordWidth-1:0] memoryData;
	logic [wordWidth-1:0] inportData;
	logic [wordWidth-1:0] bus;
	logic [wordWidth-1:0] memoryAddress;

	testRow rows[$];
	string rowNames[$];
	logic [wordWidth-1:0] seed;
	logic [wordWidth-1:0] sampled; // Bus value seen during the last step.
	int errors;
	int testsRun;
	int testsFailed;
	int errorMark;
	int assertMark;

	datapath uut (.*);

	initial begin
		Clock = 1'b0;
		forever #2 Clock = ~Clock;
	end

	function automatic logic [wordWidth-1:0] nextRandom();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic logic [wordWidth-1:0] signExtend(input logic [18:0] imm);
		return {{13{imm[18]}}, imm};
	endfunction

	function automatic busStrobes source(input string name, input int index = 0);
		busStrobes d;
		d = '0;
		case (name)
			"r": d.regOut[index] = 1'b1;
			"hi": d.hiOut = 1'b1;
			"lo": d.loOut = 1'b1;
			"zHigh": d.zHighOut = 1'b1;
			"zLow": d.zLowOut = 1'b1;
			"pc": d.pcOut = 1'b1;
			"mdr": d.mdrOut = 1'b1;
			"inport": d.inportOut = 1'b1;
			"c": d.cOut = 1'b1;
			default: begin
				errors++;
				$display("Unknown bus source %s requested by the test sequence.", name);
			end
		endcase
		return d;
	endfunction

	function automatic loadStrobes target(input string name, input int index = 0);
		loadStrobes l;
		l = '0;
		case (name)
			"r": l.regIn[index] = 1'b1;
			"hi": l.hiIn = 1'b1;
			"lo": l.loIn = 1'b1;
			"y": l.yIn = 1'b1;
			"z": l.zIn = 1'b1;
			"pc": l.pcIn = 1'b1;
			"ir": l.irIn = 1'b1;
			"mar": l.marIn = 1'b1;
			"mdr": l.mdrIn = 1'b1;
			"inport": l.inportIn = 1'b1;
			default: begin
				errors++;
				$display("Unknown load target %s requested by the test sequence.", name);
			end
		endcase
		return l;
	endfunction

	// Reference model of the ALU, low word in bits 31:0.
	function automatic logic [2*wordWidth-1:0] predict(input aluOpcode op,
			input logic [wordWidth-1:0] a, input logic [wordWidth-1:0] b);
		logic [4:0] n;
		logic [wordWidth-1:0] fill;
		logic signed [wordWidth-1:0] quotient;
		logic signed [wordWidth-1:0] remainder;
		n = b[4:0];
		fill = a[31] ? ~(32'hffff_ffff >> n) : 32'h0;
		quotient = '1; // Divide by zero leaves the dividend as remainder.
		remainder = a;
		if (b != '0) begin
			quotient = $signed(a) / $signed(b);
			remainder = $signed(a) % $signed(b);
		end
		case (op)
			opAdd: return {32'h0, a + b};
			opSub: return {32'h0, a - b};
			opAnd: return {32'h0, a & b};
			opOr: return {32'h0, a | b};
			opShra: return {32'h0, (a >> n) | fill};
			opShr: return {32'h0, a >> n};
			opShl: return {32'h0, a << n};
			opRor: return {32'h0, (a >> n) | (a << (6'd32 - {1'b0, n}))};
			opRol: return {32'h0, (a << n) | (a >> (6'd32 - {1'b0, n}))};
			opMul: return {{32{a[31]}}, a} * {{32{b[31]}}, b};
			opDiv: return {remainder, quotient};
			opNeg: return {32'h0, 32'h0 - b};
			opNot: return {32'h0, ~b};
			default: return '0;
		endcase
	endfunction

	// One control step: strobes change on the falling edge and hold for one cycle.
	task automatic step(input busStrobes d, input loadStrobes l, input logic rd = 1'b0,
			input logic inc = 1'b0, input aluOpcode op = opAdd);
		drive = d;
		load = l;
		read = rd;
		incPc = inc;
		opcode = op;
		#1;
		sampled = bus;
		@(negedge Clock);
	endtask

	task automatic check(input string name, input logic [wordWidth-1:0] want,
			input logic [wordWidth-1:0] got);
		if (got !== want) begin
			errors++;
			$display("Error %s: expected %h, actual %h", name, want, got);
		end
	endtask

	task automatic loadRegister(input int index, input logic [wordWidth-1:0] value);
		memoryData = value;
		step('0, target("mdr"), 1'b1);
		step(source("mdr"), target("r", index));
	endtask

	task automatic addRow(input string name, input aluOpcode op, input logic [wordWidth-1:0] a,
			input logic [wordWidth-1:0] b, input logic [18:0] imm);
		rows.push_back({op, a, b, imm});
		rowNames.push_back(name);
	endtask

	task automatic buildTable();
		aluOpcode randomOps [8];
		logic [wordWidth-1:0] a;
		logic [wordWidth-1:0] b;
		logic [wordWidth-1:0] value;
		addRow("add", opAdd, 32'h1234_5678, 32'h0fed_cba9, 19'h0_0100);
		addRow("sub", opSub, 32'h0000_0005, 32'h0000_0009, 19'h7_ffff);
		addRow("and", opAnd, 32'hf0f0_ff00, 32'h0ff0_0ff0, 19'h1_2345);
		addRow("or", opOr, 32'h1234_0000, 32'h0000_5678, 19'h4_0000);
		addRow("shra", opShra, 32'h8000_0f00, 32'h0000_0004, 19'h0_0000);
		addRow("shraNegative", opShra, 32'hffff_fff0, 32'h0000_001f, 19'h0_0007);
		addRow("shr", opShr, 32'h8000_0f00, 32'h0000_0004, 19'h0_0011);
		addRow("shl", opShl, 32'h0000_0f0f, 32'h0000_0008, 19'h2_0000);
		addRow("ror", opRor, 32'h1234_5678, 32'h0000_0008, 19'h0_0abc);
		addRow("rol", opRol, 32'h8765_4321, 32'h0000_0024, 19'h7_fff0);
		addRow("mul", opMul, 32'hffff_fff9, 32'h0001_e240, 19'h0_0001);
		addRow("mulLarge", opMul, 32'h7fff_ffff, 32'h7fff_ffff, 19'h3_ffff);
		addRow("div", opDiv, 32'hffff_ff9c, 32'h0000_0007, 19'h0_0002);
		addRow("divZero", opDiv, 32'h0000_04d2, 32'h0000_0000, 19'h5_5555);
		addRow("neg", opNeg, 32'h0000_0000, 32'h0000_0005, 19'h0_0003);
		addRow("not", opNot, 32'h0000_0000, 32'ha5a5_5a5a, 19'h6_0000);
		randomOps = '{opAdd, opSub, opAnd, opOr, opShra, opRor, opMul, opDiv};
		for (int i = 0; i < 8; i++) begin
			a = nextRandom();
			b = nextRandom();
			value = nextRandom();
			addRow($sformatf("random%0d", i), randomOps[i], a, b, value[18:0]);
		end
	endtask

	task automatic startTest();
		errorMark = errors;
		assertMark = uut.protocolChecks.failureCount;
	endtask

	task automatic finishTest(input string name);
		testsRun++;
		if (errors != errorMark || uut.protocolChecks.failureCount != assertMark) begin
			testsFailed++;
			$display("Test %s failed", name);
		end else begin
			$display("Test %s passed", name);
		end
	endtask

	initial begin : sequencer
		logic [wordWidth-1:0] value;
		logic [wordWidth-1:0] word;
		logic [wordWidth-1:0] expectedPc;
		logic [2*wordWidth-1:0] want;
		seed = 32'hcb9b_e75a;
		errors = 0;
		testsRun = 0;
		testsFailed = 0;
		reset = 1'b1;
		load = '0;
		drive = '0;
		read = 1'b0;
		incPc = 1'b0;
		opcode = opAdd;
		memoryData = '0;
		inportData = '0;
		buildTable();
		repeat (8) @(posedge Clock);
		@(negedge Clock);
		reset = 1'b0;

		startTest();
		step(source("pc"), '0);
		check("reset pc", '0, sampled);
		for (int r = 0; r < registerCount; r++) begin
			step(source("r", r), '0);
			check($sformatf("reset r%0d", r), '0, sampled);
		end
		finishTest("reset");

		startTest();
		value = nextRandom();
		loadRegister(5, value);
		step(source("r", 5), '0);
		check("memory r5", value, sampled);
		step(source("r", 5), target("mar"));
		check("memory address", value, memoryAddress);
		finishTest("memory");

		// T0 sends PC to MAR and PC plus one to Z, T1 updates PC and reads memory.
		startTest();
		expectedPc = '0;
		for (int k = 0; k < 3; k++) begin
			word = nextRandom();
			memoryData = word;
			step(source("pc"), target("z") | target("mar"), 1'b0, 1'b1);
			step(source("zLow"), target("pc") | target("mdr"), 1'b1);
			step(source("mdr"), target("ir"));
			expectedPc = expectedPc + 1;
			step(source("pc"), '0);
			check("fetch pc", expectedPc, sampled);
			check("fetch address", expectedPc - 1, memoryAddress);
			step(source("c"), '0);
			check("fetch constant", signExtend(word[18:0]), sampled);
		end
		finishTest("fetch");

		startTest();
		value = nextRandom();
		inportData = value;
		step('0, target("inport"));
		step(source("inport"), '0);
		check("inport", value, sampled);
		finishTest("inport");

		for (int i = 0; i < rows.size(); i++) begin
			startTest();
			want = predict(rows[i].op, rows[i].a, rows[i].b);
			loadRegister(1, rows[i].a);
			loadRegister(2, rows[i].b);
			step(source("r", 1), target("y"));
			step(source("r", 2), target("z"), 1'b0, 1'b0, rows[i].op);
			step(source("zLow"), target("lo"));
			check({rowNames[i], " low"}, want[31:0], sampled);
			step(source("zHigh"), target("hi"));
			check({rowNames[i], " high"}, want[63:32], sampled);
			step(source("lo"), '0);
			check({rowNames[i], " lo"}, want[31:0], sampled);
			step(source("hi"), '0);
			check({rowNames[i], " hi"}, want[63:32], sampled);
			// Addi of the row's immediate to register 1 through IR.
			memoryData = {5'b01100, 4'd1, 4'd1, rows[i].imm};
			step('0, target("mdr"), 1'b1);
			step(source("mdr"), target("ir"));
			step(source("r", 1), target("y"));
			step(source("c"), target("z"));
			step(source("zLow"), '0);
			check({rowNames[i], " addi"}, rows[i].a + signExtend(rows[i].imm), sampled);
			finishTest(rowNames[i]);
		end

		load = '0;
		drive = '0;
		read = 1'b0;
		incPc = 1'b0;
		@(negedge Clock);
		$display("Summary: %0d tests, %0d passed, %0d failed, %0d check errors, %0d assertion failures",
			testsRun, testsRun - testsFailed, testsFailed, errors, uut.protocolChecks.failureCount);
		if (testsFailed == 0 && errors == 0 && uut.protocolChecks.failureCount == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	// Each test takes at most 24 one-cycle steps.
	initial begin : watchdog
		int stepsPerTest;
		int limit;
		stepsPerTest = 24;
		#1;
		limit = (rows.size() + 4) * stepsPerTest * 4 + 8 * 4 + 200;
		#(limit);
		$display("Watchdog expired: the tests did not finish in the expected time.");
		$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: tb/datapath_asserts.sv
module datapath_asserts import datapathPkg::*; (
	input logic Clock,
	input logic reset,
	input loadStrobes load,
	input busStrobes drive,
	input logic [wordWidth-1:0] pc,
	input logic [wordWidth-1:0] zHigh,
	input logic [wordWidth-1:0] zLow,
	input logic [2*wordWidth-1:0] aluResult
);

	int failureCount = 0;

	// The bus has a single driver in every cycle.
	singleDriver: assert property (@(posedge Clock) disable iff (reset) $onehot0(drive))
	else begin
		failureCount++;
		$error("More than one bus source was driven in the same cycle.");
	end

	pcCleared: assert property (@(posedge Clock) $fell(reset) |-> pc == '0)
	else begin
		failureCount++;
		$error("PC was not zero when reset was released.");
	end

	// Z holds the whole 64-bit result one cycle after zIn.
	zCapture: assert property (@(posedge Clock) disable iff (reset)
		load.zIn |=> {zHigh, zLow} == $past(aluResult))
	else begin
		failureCount++;
		$error("Z did not capture the ALU result.");
	end

endmodule

bind datapath datapath_asserts protocolChecks (
	.Clock(Clock),
	.reset(reset),
	.load(load),
	.drive(drive),
	.pc(pc),
	.zHigh(zHigh),
	.zLow(zLow),
	.aluResult(aluResult)
);
